/* project.f */
+incdir+hw
hw/frontend_pkg.sv
hw/line_deserializer.sv
hw/icache.sv
hw/inst_queue.sv
hw/fetch_unit.sv
hw/frontend_top.sv
testbench/frontend_sva.sv
testbench/frontend_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = frontend_tb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/frontend_input.txt */
# M <addr hex> <word hex>                  memory word, unlisted words read as addr ^ 5a5ac3c3
# R <dequeue count> <pc hex> <order hex>   redirect once this many records have been read
# H <cycle> <length>                       hold the drain for length cycles
M aaaaa000 00000013
M aaaaa004 00100093
M aaaaa008 00208113
M aaaaa00c 003101b3
M aaaaa010 40208233
M aaaaa014 0041a2b3
M aaaaa018 00529313
M aaaaa01c 0062d393
M aaaaa040 fe010113
M aaaaa044 00112e23
M 00001000 00a00513
M 00001004 00b00593
M 00001008 00b50633
M 00001100 fff00513
M 00001104 00150513
M 00001108 fe051ee3
M 00002014 00008067
M 00002018 0000006f
H 12 60
H 95 32
H 1200 30
R 60 aaaaa040 0000000000001000
R 70 00001000 0000000000002000
R 76 00001100 0000000000003000
R 82 00001000 0000000000004000
R 88 00001100 0000000000005000
R 94 00002014 00000000fffffff8

/* testbench/frontend_tb.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module frontend_tb;

    localparam string               input_path    = "testbench/frontend_input.txt";
    localparam int                  tail_records  = 40;
    localparam int                  settle_cycles = 150;   // longer than three line fills
    localparam frontend_pkg::inst_t fill_xor      = 32'h5a5a_c3c3;

    logic                   clk;
    logic                   rst;
    frontend_pkg::addr_t    bmem_addr;
    logic                   bmem_read;
    logic                   bmem_ready;
    frontend_pkg::beat_t    bmem_rdata;
    logic                   bmem_rvalid;
    logic                   inst_valid;
    logic                   inst_ready;
    frontend_pkg::inst_t    inst;
    frontend_pkg::addr_t    inst_pc;
    frontend_pkg::order_t   inst_order;
    logic                   redirect;
    frontend_pkg::addr_t    redirect_pc;
    frontend_pkg::order_t   redirect_order;

    frontend_pkg::inst_t    mem_img [frontend_pkg::addr_t];
    int                     redir_count [$];
    frontend_pkg::addr_t    redir_pc [$];
    frontend_pkg::order_t   redir_order [$];
    int                     hold_start [$];
    int                     hold_len [$];

    // reference tag array, whole line address per set
    logic                   ref_valid [`FE_ICACHE_SETS];
    frontend_pkg::addr_t    ref_line [`FE_ICACHE_SETS];

    frontend_pkg::addr_t    exp_pc;
    frontend_pkg::order_t   exp_order;
    int                     reads;
    int                     exp_reads;
    int                     dequeued;
    int                     cycle;
    int                     errors;
    int                     checks;
    int                     tests;
    int                     limit_cycles;

    frontend_top UUT (
        .clk              (clk),
        .rst              (rst),
        .bmem_addr_o      (bmem_addr),
        .bmem_read_o      (bmem_read),
        .bmem_ready_i     (bmem_ready),
        .bmem_rdata_i     (bmem_rdata),
        .bmem_rvalid_i    (bmem_rvalid),
        .inst_valid_o     (inst_valid),
        .inst_ready_i     (inst_ready),
        .inst_o           (inst),
        .inst_pc_o        (inst_pc),
        .inst_order_o     (inst_order),
        .redirect_i       (redirect),
        .redirect_pc_i    (redirect_pc),
        .redirect_order_i (redirect_order)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic frontend_pkg::inst_t mem_word(input frontend_pkg::addr_t a);
        if (mem_img.exists(a)) return mem_img[a];
        return a ^ fill_xor;
    endfunction

    function automatic logic in_hold(input int at);
        foreach (hold_start[i]) begin
            if (at >= hold_start[i] && at < hold_start[i] + hold_len[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_inst(input frontend_pkg::inst_t got, input frontend_pkg::inst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: instruction %h at pc %h, expected %h", $time, got, exp_pc, exp);
        end
    endtask

    task automatic check_pc(input frontend_pkg::addr_t got, input frontend_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: pc %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_order(input frontend_pkg::order_t got, input frontend_pkg::order_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: order %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_reads(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t: %0d memory reads, reference expects %0d", $time, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic load_input();
        int                     fd;
        int                     code;
        int                     n;
        int                     m;
        string                  line;
        string                  kind;
        frontend_pkg::addr_t    a;
        frontend_pkg::inst_t    w;
        frontend_pkg::order_t   o;
        fd = $fopen(input_path, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", input_path);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                kind = "";
                code = $sscanf(line, "%s", kind);
                if (kind == "M") begin
                    code = $sscanf(line, "%s %h %h", kind, a, w);
                    mem_img[a] = w;
                end else if (kind == "R") begin
                    code = $sscanf(line, "%s %d %h %h", kind, n, a, o);
                    redir_count.push_back(n);
                    redir_pc.push_back(a);
                    redir_order.push_back(o);
                end else if (kind == "H") begin
                    code = $sscanf(line, "%s %d %d", kind, n, m);
                    hold_start.push_back(n);
                    hold_len.push_back(m);
                end
            end
            $fclose(fd);
        end
    endtask

    // lines fetch must touch from first up to last, in order
    task automatic model_fetch(input frontend_pkg::addr_t first, input frontend_pkg::addr_t last);
        frontend_pkg::addr_t    line_addr;
        int                     set_idx;
        line_addr = first & ~32'h1f;
        while (line_addr <= last) begin
            set_idx = int'(line_addr[31:5] % `FE_ICACHE_SETS);
            if (!ref_valid[set_idx] || ref_line[set_idx] != line_addr) begin
                exp_reads++;
                ref_valid[set_idx] = 1'b1;
                ref_line[set_idx]  = line_addr;
            end
            line_addr += 32;
        end
    endtask

    task automatic drain_until(input int target);
        while (dequeued < target) begin
            @(negedge clk);
            cycle++;
            inst_ready = !in_hold(cycle) && ($urandom_range(3, 0) != 0);
            if (inst_valid && inst_ready) begin   // read at the coming edge
                check_pc(inst_pc, exp_pc);
                check_order(inst_order, exp_order);
                check_inst(inst, mem_word(exp_pc));
                dequeued++;
                exp_pc    += 4;
                exp_order += 1;
            end
        end
    endtask

    // queue fills and the last line request completes
    task automatic settle_fetch();
        repeat (settle_cycles) begin
            @(negedge clk);
            cycle++;
            inst_ready = 1'b0;
        end
    endtask

    initial begin : memory_model
        frontend_pkg::addr_t base;
        bmem_ready  = 1'b0;
        bmem_rvalid = 1'b0;
        bmem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (bmem_read === 1'b1) begin
                base = bmem_addr;
                repeat ($urandom_range(3, 0)) @(negedge clk);
                bmem_ready = 1'b1;
                @(negedge clk);
                bmem_ready = 1'b0;
                reads++;
                for (int k = 0; k < `FE_BEATS_PER_LINE; k++) begin
                    repeat ($urandom_range(2, 0)) @(negedge clk);
                    bmem_rdata  = {mem_word(base + 8 * k + 4), mem_word(base + 8 * k)};
                    bmem_rvalid = 1'b1;
                    @(negedge clk);
                    bmem_rvalid = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: stream did not finish within %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        frontend_pkg::addr_t seg_start;
        int                  final_count;
        int                  target;
        int                  errors_before;
        int                  records_before;
        void'($urandom(32'h973e));
        rst            = 1'b1;
        inst_ready     = 1'b0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        redirect_order = '0;
        foreach (ref_valid[i]) ref_valid[i] = 1'b0;
        load_input();
        final_count  = tail_records;
        if (redir_count.size() > 0) final_count += redir_count[redir_count.size() - 1];
        limit_cycles = 200 * final_count + 2000;

        repeat (16) begin
            @(negedge clk);
            check_bit(inst_valid, 1'b0, "inst_valid_o in reset");
            check_bit(bmem_read, 1'b0, "bmem_read_o in reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_bit(inst_valid, 1'b0, "inst_valid_o after reset");
        check_bit(bmem_read, 1'b0, "bmem_read_o after reset");
        tests++;
        $display("reset: outputs idle, %0d errors", errors);

        seg_start = `FE_RESET_PC;
        exp_pc    = seg_start;
        exp_order = '0;
        for (int seg = 0; seg <= redir_count.size(); seg++) begin
            errors_before  = errors;
            records_before = dequeued;
            target = (seg < redir_count.size()) ? redir_count[seg] : final_count;
            drain_until(target);
            settle_fetch();
            // full queue leaves fetch one queue depth past the next record
            model_fetch(seg_start, exp_pc + 4 * `FE_IQ_DEPTH);
            check_reads(reads, exp_reads);
            tests++;
            $display("segment %0d from %h: %0d records, %0d reads, %0d errors", seg, seg_start,
                     dequeued - records_before, reads, errors - errors_before);
            if (seg < redir_count.size()) begin
                redirect       = 1'b1;
                redirect_pc    = redir_pc[seg];
                redirect_order = redir_order[seg];
                @(negedge clk);
                cycle++;
                redirect  = 1'b0;
                seg_start = redir_pc[seg];
                exp_pc    = seg_start;
                exp_order = redir_order[seg];
            end
        end

        $display("done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/frontend_sva.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module frontend_sva (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   read_i,
    input  frontend_pkg::addr_t    addr_i,
    input  logic                   ready_i,
    input  logic                   rvalid_i,
    input  logic                   enqueue_i,
    input  logic                   dequeue_i,
    input  logic                   flush_i
);

    int unsigned beats_due;   // beats still owed by memory
    int unsigned held;        // queue occupancy seen from its handshakes

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_due <= 0;
        end else if (read_i && ready_i) begin
            beats_due <= `FE_BEATS_PER_LINE;
        end else if (rvalid_i && beats_due != 0) begin
            beats_due <= beats_due - 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            held <= 0;
        end else if (enqueue_i && !dequeue_i) begin
            held <= held + 1;
        end else if (dequeue_i && !enqueue_i) begin
            held <= held - 1;
        end
    end

    read_held: assert property (@(posedge clk) disable iff (rst)
        read_i && !ready_i |=> read_i && $stable(addr_i))
        else $error("burst read dropped or address changed before acceptance");

    beat_expected: assert property (@(posedge clk) disable iff (rst)
        rvalid_i |-> beats_due != 0)
        else $error("memory beat with no fill outstanding");

    no_enqueue_full: assert property (@(posedge clk) disable iff (rst)
        held == `FE_IQ_DEPTH |-> !enqueue_i)
        else $error("enqueue while instruction queue full");

endmodule

bind frontend_top frontend_sva sva_checks (
    .clk       (clk),
    .rst       (rst),
    .read_i    (bmem_read_o),
    .addr_i    (bmem_addr_o),
    .ready_i   (bmem_ready_i),
    .rvalid_i  (bmem_rvalid_i),
    .enqueue_i (iq_enqueue),
    .dequeue_i (iq_dequeue),
    .flush_i   (redirect_i)
);

/* hw/frontend_top.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module frontend_top (
    input  logic                   clk,
    input  logic                   rst,

    output frontend_pkg::addr_t    bmem_addr_o,
    output logic                   bmem_read_o,
    input  logic                   bmem_ready_i,
    input  frontend_pkg::beat_t    bmem_rdata_i,
    input  logic                   bmem_rvalid_i,

    output logic                   inst_valid_o,
    input  logic                   inst_ready_i,
    output frontend_pkg::inst_t    inst_o,
    output frontend_pkg::addr_t    inst_pc_o,
    output frontend_pkg::order_t   inst_order_o,

    input  logic                   redirect_i,
    input  frontend_pkg::addr_t    redirect_pc_i,
    input  frontend_pkg::order_t   redirect_order_i
);

    logic                   req, resp;
    frontend_pkg::addr_t    addr;
    frontend_pkg::line_t    line;

    logic                   fill_req, fill_resp;
    frontend_pkg::addr_t    fill_addr;
    frontend_pkg::line_t    fill_line;

    logic                   iq_enqueue, iq_full, iq_empty, iq_dequeue;
    frontend_pkg::addr_t    iq_pc;
    frontend_pkg::inst_t    iq_inst;
    frontend_pkg::order_t   iq_order;

    assign inst_valid_o = !iq_empty;
    assign iq_dequeue   = inst_valid_o && inst_ready_i;

    fetch_unit fetch (
        .clk              (clk),
        .rst              (rst),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .redirect_order_i (redirect_order_i),
        .cache_req_o      (req),
        .cache_addr_o     (addr),
        .cache_resp_i     (resp),
        .cache_line_i     (line),
        .iq_full_i        (iq_full),
        .iq_enqueue_o     (iq_enqueue),
        .iq_pc_o          (iq_pc),
        .iq_inst_o        (iq_inst),
        .iq_order_o       (iq_order)
    );

    icache instruction_cache (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .addr_i      (addr),
        .resp_o      (resp),
        .line_o      (line),
        .fill_req_o  (fill_req),
        .fill_addr_o (fill_addr),
        .fill_resp_i (fill_resp),
        .fill_line_i (fill_line)
    );

    line_deserializer cache_line_adapter (
        .clk           (clk),
        .rst           (rst),
        .fill_req_i    (fill_req),
        .fill_addr_i   (fill_addr),
        .fill_resp_o   (fill_resp),
        .fill_line_o   (fill_line),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    inst_queue #(
        .DEPTH (`FE_IQ_DEPTH)
    ) instruction_queue (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (redirect_i),
        .enqueue_i (iq_enqueue),
        .pc_i      (iq_pc),
        .inst_i    (iq_inst),
        .order_i   (iq_order),
        .full_o    (iq_full),
        .dequeue_i (iq_dequeue),
        .pc_o      (inst_pc_o),
        .inst_o    (inst_o),
        .order_o   (inst_order_o),
        .empty_o   (iq_empty)
    );

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   redirect_i,
    input  frontend_pkg::addr_t    redirect_pc_i,
    input  frontend_pkg::order_t   redirect_order_i,

    output logic                   cache_req_o,
    output frontend_pkg::addr_t    cache_addr_o,
    input  logic                   cache_resp_i,
    input  frontend_pkg::line_t    cache_line_i,

    input  logic                   iq_full_i,
    output logic                   iq_enqueue_o,
    output frontend_pkg::addr_t    iq_pc_o,
    output frontend_pkg::inst_t    iq_inst_o,
    output frontend_pkg::order_t   iq_order_o
);

    frontend_pkg::addr_t    pc_q;
    frontend_pkg::order_t   order_q;

    // one-line buffer
    logic                   buf_valid_q;
    frontend_pkg::addr_t    buf_pc_q;
    frontend_pkg::line_t    buf_line_q;

    logic                   req_q;
    logic                   stale_q;    // response owed to a pre-redirect request
    logic                   buf_hit;

    assign buf_hit = buf_valid_q && (buf_pc_q[31:5] == pc_q[31:5]);

    assign iq_enqueue_o = buf_hit && !iq_full_i && !redirect_i;
    assign iq_pc_o      = pc_q;
    assign iq_order_o   = order_q;
    assign iq_inst_o    = buf_line_q[{pc_q[4:2], 5'b00000} +: 32];

    assign cache_req_o  = req_q;
    assign cache_addr_o = pc_q;     // stable while req is up

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q        <= `FE_RESET_PC;
            order_q     <= '0;
            buf_valid_q <= 1'b0;
            req_q       <= 1'b0;
            stale_q     <= 1'b0;
        end else if (redirect_i) begin
            pc_q        <= redirect_pc_i;
            order_q     <= redirect_order_i;
            buf_valid_q <= 1'b0;
            req_q       <= 1'b0;
            // cache still owes a response unless it comes right now
            stale_q     <= (req_q || stale_q) && !cache_resp_i;
        end else begin
            if (iq_enqueue_o) begin
                pc_q    <= pc_q + 32'd4;
                order_q <= order_q + 64'd1;
            end
            if (stale_q) begin
                if (cache_resp_i) stale_q <= 1'b0;   // dropped
            end else if (req_q) begin
                if (cache_resp_i) begin
                    req_q       <= 1'b0;
                    buf_valid_q <= 1'b1;
                end
            end else if (!buf_hit) begin
                req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!redirect_i && !stale_q && req_q && cache_resp_i) begin
            buf_pc_q   <= pc_q;
            buf_line_q <= cache_line_i;
        end
    end

endmodule

/* hw/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue #(
    parameter int DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush_i,

    input  logic                   enqueue_i,
    input  frontend_pkg::addr_t    pc_i,
    input  frontend_pkg::inst_t    inst_i,
    input  frontend_pkg::order_t   order_i,
    output logic                   full_o,

    input  logic                   dequeue_i,
    output frontend_pkg::addr_t    pc_o,
    output frontend_pkg::inst_t    inst_o,
    output frontend_pkg::order_t   order_o,
    output logic                   empty_o
);

    localparam int PTR_W = $clog2(DEPTH);

    frontend_pkg::addr_t    pc_mem    [DEPTH];
    frontend_pkg::inst_t    inst_mem  [DEPTH];
    frontend_pkg::order_t   order_mem [DEPTH];

    logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;   // wrap on power-of-two depth
    logic [PTR_W:0]    count_q;
    logic              do_enq, do_deq;

    assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_enq  = enqueue_i && !full_o;
    assign do_deq  = dequeue_i && !empty_o;

    assign pc_o    = pc_mem[rd_ptr_q];
    assign inst_o  = inst_mem[rd_ptr_q];
    assign order_o = order_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_deq) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            pc_mem[wr_ptr_q]    <= pc_i;
            inst_mem[wr_ptr_q]  <= inst_i;
            order_mem[wr_ptr_q] <= order_i;
        end
    end

endmodule

/* hw/icache.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module icache (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   req_i,
    input  frontend_pkg::addr_t    addr_i,
    output logic                   resp_o,
    output frontend_pkg::line_t    line_o,

    output logic                   fill_req_o,
    output frontend_pkg::addr_t    fill_addr_o,
    input  logic                   fill_resp_i,
    input  frontend_pkg::line_t    fill_line_i
);

    frontend_pkg::cache_state_e     state_q;
    frontend_pkg::addr_t            addr_q;      // request being served

    logic [`FE_ICACHE_SETS-1:0]     valid_q;
    frontend_pkg::tag_t             tag_q  [`FE_ICACHE_SETS];
    frontend_pkg::line_t            data_q [`FE_ICACHE_SETS];

    frontend_pkg::index_t           idx;
    frontend_pkg::tag_t             tag;
    logic                           hit;

    assign idx = addr_q[5 +: $bits(frontend_pkg::index_t)];
    assign tag = addr_q[31 -: $bits(frontend_pkg::tag_t)];
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // answer in the lookup cycle on a hit, or as the fill returns
    always_comb begin
        resp_o = 1'b0;
        line_o = data_q[idx];
        if (state_q == frontend_pkg::cache_lookup) begin
            resp_o = hit;
        end else if (state_q == frontend_pkg::cache_fill) begin
            resp_o = fill_resp_i;
            line_o = fill_line_i;   // bypass the array write
        end
    end

    assign fill_req_o  = (state_q == frontend_pkg::cache_fill);
    assign fill_addr_o = {addr_q[31:5], 5'b00000};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= frontend_pkg::cache_idle;
            valid_q <= '0;
        end else begin
            case (state_q)
                frontend_pkg::cache_idle: begin
                    if (req_i) begin
                        state_q <= frontend_pkg::cache_lookup;
                    end
                end
                frontend_pkg::cache_lookup: begin
                    if (hit) begin
                        state_q <= frontend_pkg::cache_idle;
                    end else begin
                        state_q <= frontend_pkg::cache_fill;
                    end
                end
                frontend_pkg::cache_fill: begin
                    if (fill_resp_i) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= frontend_pkg::cache_idle;
                    end
                end
                default: state_q <= frontend_pkg::cache_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == frontend_pkg::cache_idle && req_i) begin
            addr_q <= addr_i;
        end
        // line is installed even if fetch has since redirected
        if (state_q == frontend_pkg::cache_fill && fill_resp_i) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= fill_line_i;
        end
    end

endmodule

/* hw/line_deserializer.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module line_deserializer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fill_req_i,
    input  frontend_pkg::addr_t    fill_addr_i,
    output logic                   fill_resp_o,
    output frontend_pkg::line_t    fill_line_o,
    output frontend_pkg::addr_t    bmem_addr_o,
    output logic                   bmem_read_o,
    input  logic                   bmem_ready_i,
    input  frontend_pkg::beat_t    bmem_rdata_i,
    input  logic                   bmem_rvalid_i
);

    frontend_pkg::deser_state_e             state_q;
    logic [$clog2(`FE_BEATS_PER_LINE)-1:0]  beat_cnt_q;
    frontend_pkg::line_t                    line_q;
    frontend_pkg::addr_t                    addr_q;

    assign bmem_read_o = (state_q == frontend_pkg::deser_request);
    assign bmem_addr_o = addr_q;
    assign fill_line_o = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= frontend_pkg::deser_idle;
            beat_cnt_q  <= '0;
            fill_resp_o <= 1'b0;
        end else begin
            fill_resp_o <= 1'b0;
            case (state_q)
                frontend_pkg::deser_idle: begin
                    // req is still high while our resp pulse is seen
                    if (fill_req_i && !fill_resp_o) begin
                        state_q <= frontend_pkg::deser_request;
                    end
                end
                frontend_pkg::deser_request: begin
                    if (bmem_ready_i) begin
                        state_q    <= frontend_pkg::deser_collect;
                        beat_cnt_q <= '0;
                    end
                end
                frontend_pkg::deser_collect: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (int'(beat_cnt_q) == `FE_BEATS_PER_LINE - 1) begin
                            state_q     <= frontend_pkg::deser_idle;
                            fill_resp_o <= 1'b1;
                        end
                    end
                end
                default: state_q <= frontend_pkg::deser_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == frontend_pkg::deser_idle && fill_req_i) begin
            addr_q <= fill_addr_i;
        end
        if (state_q == frontend_pkg::deser_collect && bmem_rvalid_i) begin
            // beats shift down, first one ends in the low word
            line_q <= {bmem_rdata_i, line_q[255:64]};
        end
    end

endmodule

/* hw/frontend_pkg.sv */
`include "frontend_defs.svh"

package frontend_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  inst_t;
    typedef logic [63:0]  order_t;
    typedef logic [255:0] line_t;   // eight instruction words
    typedef logic [63:0]  beat_t;

    // 32-byte lines leave 5 offset bits below the index
    typedef logic [$clog2(`FE_ICACHE_SETS)-1:0]    index_t;
    typedef logic [26-$clog2(`FE_ICACHE_SETS):0]   tag_t;

    typedef enum logic [1:0] {
        cache_idle,
        cache_lookup,
        cache_fill
    } cache_state_e;

    typedef enum logic [1:0] {
        deser_idle,
        deser_request,
        deser_collect
    } deser_state_e;

endpackage

/* hw/frontend_defs.svh */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// fetch starts here out of reset
`define FE_RESET_PC 32'haaaaa000

// direct mapped, one 32-byte line per set
`define FE_ICACHE_SETS 8

// instruction queue entries, power of two
`define FE_IQ_DEPTH 16

// 64-bit memory beats per 256-bit line
`define FE_BEATS_PER_LINE 4

`endif
